//--- src.f
vga_pkg.sv
vga_timing.sv
color_lane.sv
vga_output.sv
vga_top.sv
vga_top_sva.sv
tb_vga_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the VGA raster testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_EXE=tb_vga_top_sim

verilator --binary --timing --assert -j 0 \
    --top-module tb_vga_top \
    --Mdir "$BUILD_DIR" \
    -o "$SIM_EXE" \
    -f src.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

"./$BUILD_DIR/$SIM_EXE"
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

echo "simulation finished cleanly"
exit 0

//--- tb_vga_top.sv
`default_nettype none

module tb_vga_top;

    import vga_pkg::*;

    localparam int H_DISP = 40;
    localparam int H_FP   = 4;
    localparam int H_PW   = 6;
    localparam int H_BP   = 5;
    localparam int V_DISP = 20;
    localparam int V_FP   = 2;
    localparam int V_PW   = 2;
    localparam int V_BP   = 3;

    localparam int H_TOTAL      = H_PW + H_BP + H_DISP + H_FP;    // 55
    localparam int V_TOTAL      = V_PW + V_BP + V_DISP + V_FP;    // 27
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int DRIVE_DELAY  = 2;

    typedef struct packed {
        pixel_t     pix;
        logic       hsync;
        logic       vsync;
        logic [5:0] modes;                  // r, g, b as sampled
    } expect_t;

    logic        clk;
    logic        reset;
    pattern_t    lane_mode [NUM_LANES];
    logic        hsync;
    logic        vsync;
    pixel_t      pixel;

    logic [31:0] rng_state;
    expect_t     exp_q [$];                 // Two-stage pipeline model
    int          model_h;
    int          model_v;
    int          cycle;                     // Clocks since reset release
    int          last_hs_fall;
    int          lines;                     // hsync falls since last vsync fall
    logic        prev_hsync;
    logic        prev_vsync;
    logic        vs_fell;

    vga_top #(
        .H_DISP (H_DISP), .H_FP (H_FP), .H_PW (H_PW), .H_BP (H_BP),
        .V_DISP (V_DISP), .V_FP (V_FP), .V_PW (V_PW), .V_BP (V_BP)
    ) uut (
        .clk       (clk),
        .reset     (reset),
        .lane_mode (lane_mode),
        .hsync     (hsync),
        .vsync     (vsync),
        .pixel     (pixel)
    );

    always #10 clk = ~clk;

    // ------------------------------------------------------------------------
    //  Stimulus and reference model
    // ------------------------------------------------------------------------

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    function automatic logic [5:0] channel_value(pattern_t m, int h, int v, int width);
        int full;
        int result;
        full = (1 << width) - 1;
        case (m)
            PAT_VLINES:   result = (h % 32 == 0) ? full : 0;
            PAT_HLINES:   result = (v % 32 == 0) ? full : 0;
            PAT_GRADIENT: result = (h + v) & full;     // Truncated to lane width
            default:      result = 0;
        endcase
        return 6'(result);
    endfunction

    function automatic expect_t model_output();
        expect_t e;
        logic    active;
        active = (model_h >= H_PW + H_BP) && (model_h < H_PW + H_BP + H_DISP)
              && (model_v >= V_PW + V_BP) && (model_v < V_PW + V_BP + V_DISP);
        e.hsync = !(model_h < H_PW);
        e.vsync = !(model_v < V_PW);
        e.modes = {lane_mode[0], lane_mode[1], lane_mode[2]};
        e.pix   = '0;
        if (active) begin
            e.pix.r = chan5_t'(channel_value(lane_mode[0], model_h, model_v, 5));
            e.pix.g = chan6_t'(channel_value(lane_mode[1], model_h, model_v, 6));
            e.pix.b = chan5_t'(channel_value(lane_mode[2], model_h, model_v, 5));
        end
        return e;
    endfunction

    task automatic advance_model();
        if (model_h == H_TOTAL - 1) begin
            model_h = 0;
            model_v = (model_v == V_TOTAL - 1) ? 0 : model_v + 1;
        end else begin
            model_h = model_h + 1;
        end
    endtask

    // About one clock in eight touches a random subset of lanes
    task automatic drive_modes();
        logic [31:0] rnd;
        rnd = next_random();
        if (rnd[18:16] == 3'd0) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                rnd = next_random();
                if (rnd[20]) begin
                    lane_mode[i] = pattern_t'(rnd[25:24]);
                end
            end
        end
    endtask

    // ------------------------------------------------------------------------
    //  Compare tasks
    // ------------------------------------------------------------------------

    task automatic check_pixel(input pixel_t expected, input pixel_t actual,
                               input logic [5:0] modes);
        if (actual !== expected) begin
            $display("mismatch at time %0t: pixel expected %h actual %h (modes %0d %0d %0d)",
                     $time, expected, actual, modes[5:4], modes[3:2], modes[1:0]);
            $display("Errors found");
            $fatal(1, "pixel compare failed");
        end
    endtask

    task automatic check_sync(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("mismatch at time %0t: %s expected %b actual %b",
                     $time, name, expected, actual);
            $display("Errors found");
            $fatal(1, "sync compare failed");
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("mismatch at time %0t: %s expected %0d actual %0d",
                     $time, name, expected, actual);
            $display("Errors found");
            $fatal(1, "timing count failed");
        end
    endtask

    // One clock: model the edge, compare the pins, drive the next modes
    task automatic step_cycle();
        expect_t e;
        @(posedge clk);
        exp_q.push_back(model_output());
        advance_model();
        cycle++;
        #DRIVE_DELAY;
        if (exp_q.size() == 2) begin
            e = exp_q.pop_front();
        end else begin
            e = '{pix: '0, hsync: 1'b1, vsync: 1'b1, modes: '0};   // Reset values
        end
        check_sync("hsync", e.hsync, hsync);
        check_sync("vsync", e.vsync, vsync);
        check_pixel(e.pix, pixel, e.modes);
        if (prev_hsync && !hsync) begin
            if (last_hs_fall < 0) begin
                check_count("first hsync fall cycle", 2, cycle);
            end else begin
                check_count("hsync period", H_TOTAL, cycle - last_hs_fall);
            end
            last_hs_fall = cycle;
            lines++;
        end
        if (!prev_hsync && hsync) begin
            check_count("hsync low clocks", H_PW, cycle - last_hs_fall);
        end
        if (prev_vsync && !vsync) begin
            if (cycle > 2) begin
                check_count("lines per frame", V_TOTAL, lines);
            end
            lines   = 0;
            vs_fell = 1'b1;
        end
        if (!prev_vsync && vsync) begin
            check_count("vsync low lines", V_PW, lines);
        end
        prev_hsync = hsync;
        prev_vsync = vsync;
        drive_modes();
    endtask

    task automatic wait_frame_start(input int limit);
        int n;
        n       = 0;
        vs_fell = 1'b0;
        while (!vs_fell && n < limit) begin
            step_cycle();
            n++;
        end
        if (!vs_fell) begin
            $display("timeout: frame start never arrived within %0d clocks", limit);
            $display("Errors found");
            $fatal(1, "frame timeout");
        end
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        rng_state    = 32'd24995;
        lane_mode    = '{PAT_OFF, PAT_OFF, PAT_OFF};
        model_h      = 0;
        model_v      = 0;
        cycle        = 0;
        last_hs_fall = -1;
        lines        = 0;
        prev_hsync   = 1'b1;
        prev_vsync   = 1'b1;
        vs_fell      = 1'b0;
        repeat (4) begin
            @(posedge clk);
        end
        #DRIVE_DELAY;
        check_sync("hsync", 1'b1, hsync);   // Idle levels while in reset
        check_sync("vsync", 1'b1, vsync);
        check_pixel('0, pixel, 6'd0);
        reset = 1'b0;
        drive_modes();
        wait_frame_start(FRAME_CYCLES + 8);
        repeat (3) begin
            wait_frame_start(FRAME_CYCLES + 8);
        end
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- vga_top_sva.sv
`default_nettype none

module vga_top_sva #(
    parameter int H_PW = 96
) (
    input logic                 clk,
    input logic                 reset,
    input vga_pkg::raster_pos_t pos,
    input logic                 hsync,
    input logic                 vsync,
    input vga_pkg::pixel_t      pixel
);

    logic active_d1;
    logic active_d2;                        // Active flag as seen by the pin register
    int   hs_low;                           // Consecutive clocks with hsync low

    always_ff @(posedge clk) begin
        if (reset) begin
            active_d1 <= 1'b0;
            active_d2 <= 1'b0;
            hs_low    <= 0;
        end else begin
            active_d1 <= pos.active;
            active_d2 <= active_d1;
            hs_low    <= hsync ? 0 : hs_low + 1;
        end
    end

    // ------------------------------------------------------------------------
    //  Properties
    // ------------------------------------------------------------------------

    blank_outside_window: assert property (
        @(posedge clk) disable iff (reset) !active_d2 |-> pixel == '0
    ) else $error("pixel not blanked outside the display window");

    hsync_pulse_width: assert property (
        @(posedge clk) disable iff (reset) $rose(hsync) |-> hs_low == H_PW
    ) else $error("hsync pulse width differs from H_PW");

    vsync_with_hsync: assert property (
        @(posedge clk) disable iff (reset) $fell(vsync) |-> $fell(hsync)
    ) else $error("vsync fell without an hsync fall");

endmodule

bind vga_top vga_top_sva #(.H_PW (H_PW)) u_sva (
    .clk   (clk),
    .reset (reset),
    .pos   (pos),
    .hsync (hsync),
    .vsync (vsync),
    .pixel (pixel)
);

`default_nettype wire

//--- vga_top.sv
`default_nettype none

module vga_top #(
    parameter int H_DISP = 640,
    parameter int H_FP   = 16,
    parameter int H_PW   = 96,
    parameter int H_BP   = 48,
    parameter int V_DISP = 480,
    parameter int V_FP   = 11,
    parameter int V_PW   = 2,
    parameter int V_BP   = 31
) (
    input  logic              clk,
    input  logic              reset,
    input  vga_pkg::pattern_t lane_mode [vga_pkg::NUM_LANES],   // r, g, b
    output logic              hsync,
    output logic              vsync,
    output vga_pkg::pixel_t   pixel
);

    import vga_pkg::*;

    localparam int LANE_G = 1;              // The only 6-bit lane

    raster_pos_t  pos;
    chan5_t [1:0] lane_rb;                  // Index 0 red, 1 blue
    chan5_t       lane_r;
    chan6_t       lane_g;
    chan5_t       lane_b;

    vga_timing #(
        .H_DISP (H_DISP),
        .H_FP   (H_FP),
        .H_PW   (H_PW),
        .H_BP   (H_BP),
        .V_DISP (V_DISP),
        .V_FP   (V_FP),
        .V_PW   (V_PW),
        .V_BP   (V_BP)
    ) u_timing (
        .clk   (clk),
        .reset (reset),
        .pos   (pos)
    );

    // ------------------------------------------------------------------------
    //  Colour lanes
    // ------------------------------------------------------------------------

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        if (i == LANE_G) begin : g_wide
            color_lane #(.chan_t(chan6_t)) u_lane (
                .clk (clk), .reset (reset), .pos (pos),
                .mode (lane_mode[i]), .value (lane_g)
            );
        end else begin : g_narrow
            color_lane #(.chan_t(chan5_t)) u_lane (
                .clk (clk), .reset (reset), .pos (pos),
                .mode (lane_mode[i]), .value (lane_rb[i / 2])  // r to 0, b to 1
            );
        end
    end

    assign lane_r = lane_rb[0];
    assign lane_b = lane_rb[1];

    vga_output u_output (
        .clk    (clk),
        .reset  (reset),
        .pos    (pos),
        .lane_r (lane_r),
        .lane_g (lane_g),
        .lane_b (lane_b),
        .hsync  (hsync),
        .vsync  (vsync),
        .pixel  (pixel)
    );

endmodule

`default_nettype wire

//--- vga_output.sv
`default_nettype none

module vga_output (
    input  logic                 clk,
    input  logic                 reset,
    input  vga_pkg::raster_pos_t pos,
    input  vga_pkg::chan5_t      lane_r,
    input  vga_pkg::chan6_t      lane_g,
    input  vga_pkg::chan5_t      lane_b,
    output logic                 hsync,
    output logic                 vsync,
    output vga_pkg::pixel_t      pixel
);

    import vga_pkg::*;

    logic   active_d;                   // Lines up with the lane registers
    logic   hsync_n_d;
    logic   vsync_n_d;
    pixel_t lane_pix;

    // ------------------------------------------------------------------------
    //  Align position flags with lane outputs
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            active_d  <= 1'b0;
            hsync_n_d <= 1'b1;
            vsync_n_d <= 1'b1;
        end else begin
            active_d  <= pos.active;
            hsync_n_d <= pos.hsync_n;
            vsync_n_d <= pos.vsync_n;
        end
    end

    always_comb begin
        lane_pix.r = lane_r;
        lane_pix.g = lane_g;
        lane_pix.b = lane_b;
    end

    // ------------------------------------------------------------------------
    //  Pin registers
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            hsync <= 1'b1;                      // Syncs idle high
            vsync <= 1'b1;
            pixel <= '0;
        end else begin
            hsync <= hsync_n_d;
            vsync <= vsync_n_d;
            pixel <= active_d ? lane_pix : '0;  // Blank outside window
        end
    end

endmodule

`default_nettype wire

//--- color_lane.sv
`default_nettype none

module color_lane #(
    parameter type chan_t = logic [4:0]
) (
    input  logic                 clk,
    input  logic                 reset,
    input  vga_pkg::raster_pos_t pos,
    input  vga_pkg::pattern_t    mode,
    output chan_t                value
);

    import vga_pkg::*;

    localparam chan_t FULL_SCALE = '1;

    coord_t diag;
    chan_t  pattern_val;

    // ------------------------------------------------------------------------
    //  Pattern select
    // ------------------------------------------------------------------------

    always_comb begin
        diag = pos.h + pos.v;
        case (mode)
            PAT_VLINES: begin
                pattern_val = (pos.h[4:0] == 5'd0) ? FULL_SCALE : '0;
            end
            PAT_HLINES: begin
                pattern_val = (pos.v[4:0] == 5'd0) ? FULL_SCALE : '0;
            end
            PAT_GRADIENT: begin
                pattern_val = chan_t'(diag);        // Keep low channel bits
            end
            default: begin
                pattern_val = '0;                   // PAT_OFF
            end
        endcase
    end

    // No blanking here, the output stage owns it
    always_ff @(posedge clk) begin
        if (reset) begin
            value <= '0;
        end else begin
            value <= pattern_val;
        end
    end

endmodule

`default_nettype wire

//--- vga_timing.sv
`default_nettype none

module vga_timing #(
    parameter int H_DISP = 640,
    parameter int H_FP   = 16,
    parameter int H_PW   = 96,
    parameter int H_BP   = 48,
    parameter int V_DISP = 480,
    parameter int V_FP   = 11,
    parameter int V_PW   = 2,
    parameter int V_BP   = 31
) (
    input  logic                 clk,
    input  logic                 reset,
    output vga_pkg::raster_pos_t pos
);

    import vga_pkg::*;

    // Region boundaries, sync pulse first then back porch
    localparam coord_t H_LAST  = coord_t'(H_PW + H_BP + H_DISP + H_FP - 1);
    localparam coord_t H_START = coord_t'(H_PW + H_BP);
    localparam coord_t H_END   = coord_t'(H_PW + H_BP + H_DISP);
    localparam coord_t H_SYNC  = coord_t'(H_PW);

    localparam coord_t V_LAST  = coord_t'(V_PW + V_BP + V_DISP + V_FP - 1);
    localparam coord_t V_START = coord_t'(V_PW + V_BP);
    localparam coord_t V_END   = coord_t'(V_PW + V_BP + V_DISP);
    localparam coord_t V_SYNC  = coord_t'(V_PW);

    coord_t h_count;
    coord_t v_count;

    // ------------------------------------------------------------------------
    //  Wrapping H/V counters
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            h_count <= '0;
            v_count <= '0;
        end else if (h_count == H_LAST) begin
            h_count <= '0;                          // End of line
            if (v_count == V_LAST) begin
                v_count <= '0;                      // End of frame
            end else begin
                v_count <= v_count + coord_t'(1);
            end
        end else begin
            h_count <= h_count + coord_t'(1);
        end
    end

    // Flags decoded straight from the counters
    always_comb begin
        pos.h       = h_count;
        pos.v       = v_count;
        pos.hsync_n = ~(h_count < H_SYNC);
        pos.vsync_n = ~(v_count < V_SYNC);
        pos.active  = (h_count >= H_START) && (h_count < H_END)
                   && (v_count >= V_START) && (v_count < V_END);
    end

endmodule

`default_nettype wire

//--- vga_pkg.sv
`default_nettype none

package vga_pkg;

    // ------------------------------------------------------------------------
    //  Raster coordinates
    // ------------------------------------------------------------------------

    typedef logic [10:0] coord_t;           // Totals up to 2047

    typedef struct packed {
        coord_t h;
        coord_t v;
        logic   active;                     // Inside display window
        logic   hsync_n;
        logic   vsync_n;
    } raster_pos_t;

    // ------------------------------------------------------------------------
    //  Colour channels, RGB 5-6-5
    // ------------------------------------------------------------------------

    typedef logic [4:0] chan5_t;
    typedef logic [5:0] chan6_t;

    typedef struct packed {
        chan5_t r;
        chan6_t g;
        chan5_t b;
    } pixel_t;

    localparam int NUM_LANES = 3;           // Lane order r, g, b

    // Per-lane test pattern
    typedef enum logic [1:0] {
        PAT_OFF      = 2'd0,
        PAT_VLINES   = 2'd1,                // Full scale every 32 columns
        PAT_HLINES   = 2'd2,                // Full scale every 32 lines
        PAT_GRADIENT = 2'd3                 // h + v, truncated
    } pattern_t;

endpackage

`default_nettype wire
